/* include/rsa256_defines.svh */
`ifndef RSA256_DEFINES_SVH
`define RSA256_DEFINES_SVH

// operand width, for N, d, y and the result
`define RSA256_WIDTH 256

// montgomery accumulator
// holds values below 2N plus one carry bit
`define RSA256_EXT_WIDTH 258

// bit index and round counter
// one bit more than needed to index an operand
`define RSA256_CNT_WIDTH 9

`endif

/* source/rsa256_pkg.sv */
`include "rsa256_defines.svh"

package rsa256_pkg;

    // operands and results
    typedef logic [`RSA256_WIDTH-1:0] word_t;

    // montgomery accumulator with headroom
    typedef logic [`RSA256_EXT_WIDTH-1:0] ext_word_t;

    // loop index over the operand bits
    typedef logic [`RSA256_CNT_WIDTH-1:0] bit_idx_t;

    typedef enum logic [1:0] {MONT_IDLE, MONT_PREP, MONT_CALC} mont_state_e;

    typedef enum logic {PM_IDLE, PM_RUN} premult_state_e;

    typedef enum logic [2:0] {
        CTRL_IDLE, CTRL_PREMULT, CTRL_MONT_START, CTRL_MONT_WAIT, CTRL_FINISH
    } ctrl_state_e;

endpackage

/* source/rsa256_ifs.sv */
`timescale 1ns/1ps

// request/response link to one montgomery multiplier
// a, b and n stay stable from start until done
interface mont_if;
    logic                  start;
    rsa256_pkg::word_t     a;
    rsa256_pkg::ext_word_t b;
    rsa256_pkg::ext_word_t n;
    rsa256_pkg::word_t     result;
    logic                  done;

    modport master (
        output start, a, b, n,
        input  result, done
    );

    modport slave (
        input  start, a, b, n,
        output result, done
    );
endinterface

// link to the pre-multiplier, same start/done rule
interface premult_if;
    logic              start;
    rsa256_pkg::word_t y;
    rsa256_pkg::word_t n;
    rsa256_pkg::word_t result;
    logic              done;

    modport master (
        output start, y, n,
        input  result, done
    );

    modport slave (
        input  start, y, n,
        output result, done
    );
endinterface

/* source/mont_mult.sv */
`timescale 1ns/1ps
`include "rsa256_defines.svh"

module mont_mult (
    input  logic  i_clk,
    input  logic  i_rst,
    mont_if.slave bus
);

    rsa256_pkg::mont_state_e state_r, state_w;
    rsa256_pkg::ext_word_t   acc_r, acc_w;
    rsa256_pkg::ext_word_t   sum_ab;
    rsa256_pkg::bit_idx_t    idx_r, idx_w;
    logic                    done_r, done_w;

    assign bus.result = acc_r[`RSA256_WIDTH-1:0];
    assign bus.done   = done_r;

    // acc plus b when the current bit of a is set
    always_comb begin
        if (bus.a[idx_r[`RSA256_CNT_WIDTH-2:0]]) begin
            sum_ab = acc_r + bus.b;
        end else begin
            sum_ab = acc_r;
        end
    end

    always_comb begin
        state_w = state_r;
        acc_w   = acc_r;
        idx_w   = idx_r;
        done_w  = 1'b0;
        case (state_r)
            rsa256_pkg::MONT_IDLE: begin
                if (bus.start) begin
                    state_w = rsa256_pkg::MONT_PREP;
                    acc_w   = '0;
                    idx_w   = '0;
                end
            end
            rsa256_pkg::MONT_PREP: begin
                state_w = rsa256_pkg::MONT_CALC;
                // make the sum even before halving
                if (sum_ab[0]) begin
                    acc_w = (sum_ab + bus.n) >> 1;
                end else begin
                    acc_w = sum_ab >> 1;
                end
            end
            rsa256_pkg::MONT_CALC: begin
                if (idx_r == rsa256_pkg::bit_idx_t'(`RSA256_WIDTH - 1)) begin
                    state_w = rsa256_pkg::MONT_IDLE;
                    done_w  = 1'b1;
                    // acc is below 2N here, one subtraction is enough
                    if (acc_r >= bus.n) begin
                        acc_w = acc_r - bus.n;
                    end
                end else begin
                    state_w = rsa256_pkg::MONT_PREP;
                    idx_w   = idx_r + 1'b1;
                end
            end
            default: state_w = rsa256_pkg::MONT_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= rsa256_pkg::MONT_IDLE;
            idx_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            state_r <= state_w;
            idx_r   <= idx_w;
            done_r  <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        acc_r <= acc_w;
    end

endmodule

/* source/mod_premult.sv */
`timescale 1ns/1ps
`include "rsa256_defines.svh"

module mod_premult (
    input  logic     i_clk,
    input  logic     i_rst,
    premult_if.slave bus
);

    rsa256_pkg::premult_state_e state_r;
    rsa256_pkg::bit_idx_t       cnt_r;
    rsa256_pkg::ext_word_t      val_r;
    rsa256_pkg::ext_word_t      n_ext;
    rsa256_pkg::ext_word_t      dbl;
    logic                       done_r;

    assign n_ext = rsa256_pkg::ext_word_t'(bus.n);

    // val stays below N, so the doubled value fits with room to spare
    assign dbl = {val_r[`RSA256_EXT_WIDTH-2:0], 1'b0};

    assign bus.result = val_r[`RSA256_WIDTH-1:0];
    assign bus.done   = done_r;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= rsa256_pkg::PM_IDLE;
            cnt_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                rsa256_pkg::PM_IDLE: begin
                    if (bus.start) begin
                        state_r <= rsa256_pkg::PM_RUN;
                        cnt_r   <= '0;
                    end
                end
                rsa256_pkg::PM_RUN: begin
                    if (cnt_r == rsa256_pkg::bit_idx_t'(`RSA256_WIDTH - 1)) begin
                        state_r <= rsa256_pkg::PM_IDLE;
                        done_r  <= 1'b1;
                    end else begin
                        cnt_r <= cnt_r + 1'b1;
                    end
                end
                default: state_r <= rsa256_pkg::PM_IDLE;
            endcase
        end
    end

    // one doubling and conditional reduction per run cycle
    always_ff @(posedge i_clk) begin
        if (state_r == rsa256_pkg::PM_IDLE && bus.start) begin
            val_r <= rsa256_pkg::ext_word_t'(bus.y);
        end else if (state_r == rsa256_pkg::PM_RUN) begin
            val_r <= (dbl >= n_ext) ? dbl - n_ext : dbl;
        end
    end

endmodule

/* source/rsa256_ctrl.sv */
`timescale 1ns/1ps
`include "rsa256_defines.svh"

module rsa256_ctrl (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_start,
    input  rsa256_pkg::word_t i_n,
    input  rsa256_pkg::word_t i_d,
    input  rsa256_pkg::word_t i_y,
    output rsa256_pkg::word_t o_result,
    output logic              o_valid,
    output logic              o_busy,
    premult_if.master         pm,
    mont_if.master            mul,
    mont_if.master            sqr
);

    rsa256_pkg::ctrl_state_e state_r;
    rsa256_pkg::bit_idx_t    round_r;
    logic                    pm_start_r;
    logic                    valid_r;
    rsa256_pkg::word_t       result_r;

    // latched operands and loop registers
    rsa256_pkg::word_t n_r, d_r, y_r;
    rsa256_pkg::word_t t_r;
    rsa256_pkg::word_t m_r;

    assign o_result = result_r;
    assign o_valid  = valid_r;
    assign o_busy   = (state_r != rsa256_pkg::CTRL_IDLE);

    assign pm.start = pm_start_r;
    assign pm.y     = y_r;
    assign pm.n     = n_r;

    // t is in montgomery form, m stays in the normal domain
    assign mul.start = (state_r == rsa256_pkg::CTRL_MONT_START);
    assign mul.a     = t_r;
    assign mul.b     = rsa256_pkg::ext_word_t'(m_r);
    assign mul.n     = rsa256_pkg::ext_word_t'(n_r);

    assign sqr.start = (state_r == rsa256_pkg::CTRL_MONT_START);
    assign sqr.a     = t_r;
    assign sqr.b     = rsa256_pkg::ext_word_t'(t_r);
    assign sqr.n     = rsa256_pkg::ext_word_t'(n_r);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r    <= rsa256_pkg::CTRL_IDLE;
            round_r    <= '0;
            pm_start_r <= 1'b0;
            valid_r    <= 1'b0;
            result_r   <= '0;
        end else begin
            pm_start_r <= 1'b0;
            valid_r    <= 1'b0;
            case (state_r)
                rsa256_pkg::CTRL_IDLE: begin
                    // starts during a run never reach this state
                    if (i_start) begin
                        state_r    <= rsa256_pkg::CTRL_PREMULT;
                        pm_start_r <= 1'b1;
                    end
                end
                rsa256_pkg::CTRL_PREMULT: begin
                    if (pm.done) begin
                        state_r <= rsa256_pkg::CTRL_MONT_START;
                        round_r <= '0;
                    end
                end
                rsa256_pkg::CTRL_MONT_START: begin
                    state_r <= rsa256_pkg::CTRL_MONT_WAIT;
                end
                rsa256_pkg::CTRL_MONT_WAIT: begin
                    if (mul.done) begin
                        if (round_r == rsa256_pkg::bit_idx_t'(`RSA256_WIDTH - 1)) begin
                            state_r <= rsa256_pkg::CTRL_FINISH;
                        end else begin
                            state_r <= rsa256_pkg::CTRL_MONT_START;
                            round_r <= round_r + 1'b1;
                        end
                    end
                end
                rsa256_pkg::CTRL_FINISH: begin
                    state_r  <= rsa256_pkg::CTRL_IDLE;
                    result_r <= m_r;
                    valid_r  <= 1'b1;
                end
                default: state_r <= rsa256_pkg::CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == rsa256_pkg::CTRL_IDLE && i_start) begin
            n_r <= i_n;
            d_r <= i_d;
            y_r <= i_y;
        end else if (state_r == rsa256_pkg::CTRL_PREMULT && pm.done) begin
            t_r <= pm.result;
            m_r <= rsa256_pkg::word_t'(1);
        end else if (state_r == rsa256_pkg::CTRL_MONT_WAIT && mul.done) begin
            // square every round, multiply only on a set exponent bit
            t_r <= sqr.result;
            if (d_r[0]) begin
                m_r <= mul.result;
            end
            d_r <= d_r >> 1;
        end
    end

endmodule

/* source/rsa256_core.sv */
`timescale 1ns/1ps

module rsa256_core (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_start,
    input  rsa256_pkg::word_t i_n,
    input  rsa256_pkg::word_t i_d,
    input  rsa256_pkg::word_t i_y,
    output rsa256_pkg::word_t o_result,
    output logic              o_valid,
    output logic              o_busy
);

    premult_if pm_bus ();
    // product and squaring run side by side
    mont_if    mul_bus ();
    mont_if    sqr_bus ();

    rsa256_ctrl i_ctrl (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_n      (i_n),
        .i_d      (i_d),
        .i_y      (i_y),
        .o_result (o_result),
        .o_valid  (o_valid),
        .o_busy   (o_busy),
        .pm       (pm_bus.master),
        .mul      (mul_bus.master),
        .sqr      (sqr_bus.master)
    );

    mod_premult i_premult (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .bus   (pm_bus.slave)
    );

    mont_mult i_mont_mul (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .bus   (mul_bus.slave)
    );

    mont_mult i_mont_sqr (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .bus   (sqr_bus.slave)
    );

endmodule

/* sim/rsa256_assertions.sv */
`timescale 1ns/1ps

module rsa256_assertions (
    input logic              i_clk,
    input logic              i_rst,
    input logic              i_valid,
    input logic              i_busy,
    input rsa256_pkg::word_t i_result,
    input rsa256_pkg::word_t i_n,
    input logic              i_mul_done,
    input logic              i_sqr_done
);

    // result pulse is a single cycle
    valid_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_valid |=> !i_valid)
        else $error("o_valid stayed high for more than one cycle");

    valid_not_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_valid && i_busy))
        else $error("o_valid and o_busy high together");

    // both multipliers start together, so they must finish together
    done_in_step: assert property (@(posedge i_clk) disable iff (i_rst)
        i_mul_done == i_sqr_done)
        else $error("mul and sqr done out of step");

    result_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
        i_valid |-> (i_result < i_n))
        else $error("o_result not below the latched modulus");

endmodule

bind rsa256_ctrl rsa256_assertions i_assertions (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (o_valid),
    .i_busy     (o_busy),
    .i_result   (o_result),
    .i_n        (n_r),
    .i_mul_done (mul.done),
    .i_sqr_done (sqr.done)
);

/* sim/tb_rsa256.sv */
`timescale 1ns/1ps

module tb_rsa256;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_VEC    = 32;
    localparam int VEC_CYCLES = 140000;
    // vector whose run gets a second start while busy
    localparam int INJECT_VEC = 1;

    logic              i_clk;
    logic              i_rst;
    logic              i_start;
    rsa256_pkg::word_t i_n;
    rsa256_pkg::word_t i_d;
    rsa256_pkg::word_t i_y;
    rsa256_pkg::word_t o_result;
    logic              o_valid;
    logic              o_busy;

    // word 0 is the count, then N, d, y and expected for each vector
    rsa256_pkg::word_t pat_mem [0:4*MAX_VEC];
    int                num_vec;
    logic              loaded = 1'b0;
    integer            seed;

    rsa256_core i_dut (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_n      (i_n),
        .i_d      (i_d),
        .i_y      (i_y),
        .o_result (o_result),
        .o_valid  (o_valid),
        .o_busy   (o_busy)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic check_word(input string name, input rsa256_pkg::word_t got,
                              input rsa256_pkg::word_t expected);
        assert (got === expected) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        assert (got === expected) else begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // inputs change and outputs are read 1 ns after the edge
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    // core idle, result must hold
    task automatic idle_gap(input int cycles, input rsa256_pkg::word_t held);
        for (int c = 0; c < cycles; c++) begin
            next_cycle();
            check_bit("o_valid", o_valid, 1'b0);
            check_bit("o_busy", o_busy, 1'b0);
            check_word("o_result", o_result, held);
        end
    endtask

    task automatic run_vector(input int v, input bit inject, inout rsa256_pkg::word_t held);
        rsa256_pkg::word_t expected;
        int                cycles;
        expected = pat_mem[4*v+4];
        cycles   = 0;
        i_n      = pat_mem[4*v+1];
        i_d      = pat_mem[4*v+2];
        i_y      = pat_mem[4*v+3];
        i_start  = 1'b1;
        do begin
            next_cycle();
            i_start = 1'b0;
            cycles++;
            // other operands, same start pulse, core is busy
            if (inject && cycles == 64) begin
                i_n     = ~i_n;
                i_d     = ~i_d;
                i_y     = ~i_y >> 1;
                i_start = 1'b1;
            end
            if (!o_valid) begin
                check_bit("o_busy", o_busy, 1'b1);
                check_word("o_result", o_result, held);
            end
        end while (!o_valid);
        check_bit("o_busy", o_busy, 1'b0);
        check_word("o_result", o_result, expected);
        held = expected;
    endtask

    initial begin
        rsa256_pkg::word_t held;
        int                gap;
        i_clk   = 1'b0;
        i_rst   = 1'b1;
        i_start = 1'b0;
        i_n     = '0;
        i_d     = '0;
        i_y     = '0;
        seed    = 32'hf1e7b02b;
        $readmemh("sim/rsa256_patterns.txt", pat_mem);
        num_vec = int'(pat_mem[0][31:0]);
        assert (num_vec > 0 && num_vec <= MAX_VEC) else begin
            $display("ERROR: pattern file gives %0d vectors, allowed 1 to %0d", num_vec, MAX_VEC);
            $display("Simulation FAILED");
            $fatal(1, "bad pattern file");
        end
        loaded = 1'b1;

        repeat (4) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        // nothing comes out before the first start
        held = '0;
        idle_gap(3, held);

        for (int v = 0; v < num_vec; v++) begin
            // every fourth vector starts in the cycle after o_valid
            if (v % 4 == 3) begin
                gap = 1;
            end else begin
                gap = 1 + ($random(seed) & 7);
            end
            idle_gap(gap, held);
            run_vector(v, v == INJECT_VEC, held);
            if (v == INJECT_VEC) begin
                idle_gap(16, held);
            end
        end

        idle_gap(16, held);
        $display("Simulation PASSED");
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(CLK_PERIOD) * (4 + longint'(num_vec) * VEC_CYCLES);
        #(limit_ns);
        $display("ERROR: timeout after %0d ns, the core never raised o_valid", limit_ns);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* rsa256.f */
+incdir+include
source/rsa256_pkg.sv
source/rsa256_ifs.sv
source/mont_mult.sv
source/mod_premult.sv
source/rsa256_ctrl.sv
source/rsa256_core.sv
sim/rsa256_assertions.sv
sim/tb_rsa256.sv

/* run_sim.sh */
#!/bin/sh
# builds the rsa256 testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f rsa256.f --top-module tb_rsa256

./obj_dir/Vtb_rsa256 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    echo "run_sim: failure reported in $LOG"
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "run_sim: run ended without a pass line, see $LOG"
    exit 1
fi
echo "run_sim: done"

/* sim/rsa256_patterns.txt */
// first line: number of vectors
// then one vector per line: N d y expected, all hex, expected = y^d mod N
e
c7a13f5e92d46b081e7fa3c55d2984b60f3e7a91c2d846b5e91a3c0758f2d6e3 5f0a93c27e418db6a2c5f0319e7b64d8c3a1f5072be96d4085f3c1a7e29b6d5b c7a13f5e92d46b081e7fa3c55d2984b60f3e7a91c2d846b5e91a3c0758f2d6e2 c7a13f5e92d46b081e7fa3c55d2984b60f3e7a91c2d846b5e91a3c0758f2d6e2
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 5f0a93c27e418db6a2c5f0319e7b64d8c3a1f5072be96d4085f3c1a7e29b6d5b 2 80000000000000000000000
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 8e3b27f1c94a065d3f82b1e7a05c9d4612fe8b37c6a0d9254e71b3f8a2c6d09e 8000000000000000000000000000000000000000000000000000000000000000 4000000000000000000000000
b3e5099d4f21c68a7d0e53b2a9f4618c3d57e0a2964bf18e5c20d7a3f16b49c5 8e3b27f1c94a065d3f82b1e7a05c9d4612fe8b37c6a0d9254e71b3f8a2c6d09e b3e5099d4f21c68a7d0e53b2a9f4618c3d57e0a2964bf18e5c20d7a3f16b49c4 1
b3e5099d4f21c68a7d0e53b2a9f4618c3d57e0a2964bf18e5c20d7a3f16b49c5 0 a4c70e5b913f2d86c05b7a19e3d6f2408b1c59e7d3a06f42b8e9c1d5073fa6e1 1
c7a13f5e92d46b081e7fa3c55d2984b60f3e7a91c2d846b5e91a3c0758f2d6e3 1 7d19c4e2a05f8b3361d7e9c40a2b5f1893e6d07c4a18b2f5e69d031c7b4a8e2f 7d19c4e2a05f8b3361d7e9c40a2b5f1893e6d07c4a18b2f5e69d031c7b4a8e2f
b3e5099d4f21c68a7d0e53b2a9f4618c3d57e0a2964bf18e5c20d7a3f16b49c5 1 a4c70e5b913f2d86c05b7a19e3d6f2408b1c59e7d3a06f42b8e9c1d5073fa6e1 a4c70e5b913f2d86c05b7a19e3d6f2408b1c59e7d3a06f42b8e9c1d5073fa6e1
c7a13f5e92d46b081e7fa3c55d2984b60f3e7a91c2d846b5e91a3c0758f2d6e3 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff c7a13f5e92d46b081e7fa3c55d2984b60f3e7a91c2d846b5e91a3c0758f2d6e2 c7a13f5e92d46b081e7fa3c55d2984b60f3e7a91c2d846b5e91a3c0758f2d6e2
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 8000000000000000000000000000000000000000000000000000000000000000 2
d ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 2 8
c7a13f5e92d46b081e7fa3c55d2984b60f3e7a91c2d846b5e91a3c0758f2d6e3 8e3b27f1c94a065d3f82b1e7a05c9d4612fe8b37c6a0d9254e71b3f8a2c6d09e 0 0
b3e5099d4f21c68a7d0e53b2a9f4618c3d57e0a2964bf18e5c20d7a3f16b49c5 5f0a93c27e418db6a2c5f0319e7b64d8c3a1f5072be96d4085f3c1a7e29b6d5b 1 1
3d 1f 2 3b
10001 8000 3 10000
